//--- bench/tb_rcc_top.sv
`default_nettype none

module tb_rcc_top;

  import rcc_clk_pkg::*;
  import rcc_reg_pkg::*;

  localparam int HCLK_PERIOD = 20;
  localparam int RST_CYCLES  = 10;
  localparam int TEST_CYCLES = 20 + 40 + 80 + 40 + 40 + 200;  // budget per test, summed
  localparam int MARGIN      = 100;

  logic              rst_n;
  logic              sys_clk;
  logic              rcc_rcc_hclk;
  logic [N_OSC-1:0]  osc_rdy;
  logic              lsecss_fail;
  logic              hsecss_fail;
  logic              reg_sel;
  logic              reg_wr;
  logic [ADDR_W-1:0] reg_addr;
  logic [DATA_W-1:0] reg_wdata;
  logic [DATA_W-1:0] reg_rdata;
  logic              reg_rvalid;
  logic [N_OSC-1:0]  osc_en;
  clk_src_e          sys_clk_sel;
  logic              rcc_irq;
  logic              css_nmi;

  int errors        = 0;
  int nmi_errors    = 0;  // counted by the NMI property
  int rvalid_errors = 0;  // counted by the bus property
  int err_mark      = 0;
  int tests_ok      = 0;
  int tests_bad     = 0;

  rcc_top #(
    .STAGE_NUM (SYNC_STAGES)
  ) u_rcc_top (
    .rst_n        (rst_n),
    .sys_clk      (sys_clk),
    .rcc_rcc_hclk (rcc_rcc_hclk),
    .osc_rdy      (osc_rdy),
    .lsecss_fail  (lsecss_fail),
    .hsecss_fail  (hsecss_fail),
    .reg_sel      (reg_sel),
    .reg_wr       (reg_wr),
    .reg_addr     (reg_addr),
    .reg_wdata    (reg_wdata),
    .reg_rdata    (reg_rdata),
    .reg_rvalid   (reg_rvalid),
    .osc_en       (osc_en),
    .sys_clk_sel  (sys_clk_sel),
    .rcc_irq      (rcc_irq),
    .css_nmi      (css_nmi)
  );

  initial begin
    rcc_rcc_hclk = 1'b0;
    forever #(HCLK_PERIOD / 2) rcc_rcc_hclk = ~rcc_rcc_hclk;
  end

  initial begin
    sys_clk = 1'b0;
    #7;  // keeps the two clock domains out of phase
    forever #(HCLK_PERIOD / 2) sys_clk = ~sys_clk;
  end

  // ***************************************************************************
  // properties
  // ***************************************************************************
  css_nmi_on_fail: assert property (@(posedge rcc_rcc_hclk) hsecss_fail |-> css_nmi)
    else begin
      $display("[ERROR] %0t: css_nmi expected 1 got %b", $time, css_nmi);
      nmi_errors++;
    end

  rvalid_after_read: assert property (@(posedge rcc_rcc_hclk) disable iff (!rst_n)
    (reg_sel && !reg_wr) |=> reg_rvalid)
    else begin
      $display("[ERROR] %0t: reg_rvalid expected 1 got %b", $time, reg_rvalid);
      rvalid_errors++;
    end

  function automatic int total_errors();
    return errors + nmi_errors + rvalid_errors;
  endfunction

  task automatic check_value(input string name, input logic [DATA_W-1:0] expected,
                             input logic [DATA_W-1:0] actual);
    assert (actual === expected)
      else begin
        $display("[ERROR] %0t: %s expected %h got %h", $time, name, expected, actual);
        errors++;
      end
  endtask

  task automatic report_failure(input string what);
    $display("[ERROR] %0t: %s", $time, what);
    errors++;
  endtask

  task automatic wait_cycles(input int n);
    repeat (n) @(negedge rcc_rcc_hclk);
  endtask

  // bus tasks are entered and left on a falling hclk edge
  task automatic reg_write(input logic [ADDR_W-1:0] addr, input logic [DATA_W-1:0] data);
    reg_sel   = 1'b1;
    reg_wr    = 1'b1;
    reg_addr  = addr;
    reg_wdata = data;
    @(negedge rcc_rcc_hclk);
    reg_sel = 1'b0;
    reg_wr  = 1'b0;
  endtask

  task automatic reg_read(input logic [ADDR_W-1:0] addr, output logic [DATA_W-1:0] data);
    int waited;
    reg_sel  = 1'b1;
    reg_wr   = 1'b0;
    reg_addr = addr;
    @(negedge rcc_rcc_hclk);
    reg_sel = 1'b0;
    waited  = 0;
    while (!reg_rvalid && waited < 4) begin
      @(negedge rcc_rcc_hclk);
      waited++;
    end
    if (!reg_rvalid) report_failure("a register read never returned reg_rvalid");
    data = reg_rdata;
  endtask

  task automatic start_test();
    err_mark = total_errors();
  endtask

  task automatic end_test(input string name);
    int found;
    found = total_errors() - err_mark;
    if (found == 0) begin
      tests_ok++;
      $display("%s: ok", name);
    end else begin
      tests_bad++;
      $display("%s: %0d errors", name, found);
    end
  endtask

  initial begin
    #((RST_CYCLES + TEST_CYCLES + MARGIN) * HCLK_PERIOD);
    $display("timeout: the tests did not finish within their cycle budget");
    $display("Test failed");
    $finish;
  end

  // ***************************************************************************
  // tests
  // ***************************************************************************
  initial begin
    logic [DATA_W-1:0] rd;
    logic [DATA_W-1:0] val;
    logic [N_OSC-1:0]  subset;
    logic [N_OSC-1:0]  masked;
    logic [N_OSC-1:0]  enabled;
    int                n;
    int                i;

    void'($urandom(37008));
    rst_n       = 1'b0;
    osc_rdy     = '0;
    lsecss_fail = 1'b0;
    hsecss_fail = 1'b0;
    reg_sel     = 1'b0;
    reg_wr      = 1'b0;
    reg_addr    = '0;
    reg_wdata   = '0;
    repeat (RST_CYCLES) @(posedge rcc_rcc_hclk);
    @(negedge rcc_rcc_hclk);
    rst_n = 1'b1;
    wait_cycles(4);  // synchronized hclk reset lets go after two edges

    start_test();
    check_value("osc_en", CR_RST & 32'h1ff, 32'(osc_en));
    check_value("sys_clk_sel", 32'(CLK_HSI), 32'(sys_clk_sel));
    check_value("rcc_irq", 32'd0, 32'(rcc_irq));
    check_value("reg_rvalid", 32'd0, 32'(reg_rvalid));
    reg_read(CIFR_OFS, rd);
    check_value("CIFR", 32'd0, rd);
    end_test("reset values");

    start_test();
    subset  = (9'($urandom) & 9'h016) | 9'h001;
    osc_rdy = subset;
    reg_read(SR_OFS, rd);  // strobe lands on the same edge as the input change
    check_value("SR", 32'd0, rd);
    wait_cycles(2);
    reg_read(SR_OFS, rd);
    check_value("SR", 32'(subset), rd);
    end_test("ready sync");

    start_test();
    reg_write(CICR_OFS, 32'hffff_ffff);
    wait_cycles(1);
    reg_read(CIFR_OFS, rd);
    check_value("CIFR", 32'd0, rd);
    masked  = 9'(1 << PLL2_IDX) | 9'(1 << PLL3_IDX);
    enabled = 9'(1 << PLL1_IDX) | 9'(1 << LSE_IDX);
    reg_write(CIER_OFS, 32'(enabled));
    osc_rdy = osc_rdy | masked;
    repeat (5) begin
      @(negedge rcc_rcc_hclk);
      check_value("rcc_irq", 32'd0, 32'(rcc_irq));
    end
    reg_read(CIFR_OFS, rd);
    check_value("CIFR", 32'(masked), rd);
    osc_rdy = osc_rdy | enabled;
    n = 0;
    while (!rcc_irq && n < 6) begin
      @(negedge rcc_rcc_hclk);
      n++;
    end
    if (!rcc_irq) report_failure("rcc_irq did not rise for an enabled ready flag");
    reg_read(CIFR_OFS, rd);
    check_value("CIFR", 32'(masked | enabled), rd);
    reg_write(CICR_OFS, 32'(enabled));
    wait_cycles(2);
    check_value("rcc_irq", 32'd0, 32'(rcc_irq));
    reg_read(CIFR_OFS, rd);
    check_value("CIFR", 32'(masked), rd);
    reg_write(CICR_OFS, 32'hffff_ffff);
    wait_cycles(2);
    end_test("interrupts");

    start_test();
    reg_write(CFGR_OFS, 32'(CLK_HSE));
    wait_cycles(5);
    check_value("sys_clk_sel", 32'(CLK_HSI), 32'(sys_clk_sel));
    reg_read(CFGR_OFS, rd);
    check_value("CFGR", 32'h2, rd);  // request pending, still on HSI
    osc_rdy[HSE_IDX] = 1'b1;
    n = 0;
    while (sys_clk_sel != CLK_HSE && n < 4) begin
      @(negedge rcc_rcc_hclk);
      n++;
    end
    check_value("sys_clk_sel", 32'(CLK_HSE), 32'(sys_clk_sel));
    reg_read(CFGR_OFS, rd);
    check_value("CFGR", 32'ha, rd);
    end_test("clock switch");

    start_test();
    hsecss_fail = 1'b1;
    #1;
    check_value("css_nmi", 32'd1, 32'(css_nmi));
    @(negedge rcc_rcc_hclk);
    n = 1;
    while (sys_clk_sel != CLK_HSI && n < 4) begin
      @(negedge rcc_rcc_hclk);
      n++;
    end
    check_value("sys_clk_sel", 32'(CLK_HSI), 32'(sys_clk_sel));
    reg_read(CIFR_OFS, rd);
    check_value("CIFR css flag", 32'd1, 32'(rd[CSS_BIT]));
    hsecss_fail = 1'b0;
    n = 0;
    while (css_nmi && n < 3) begin
      @(posedge sys_clk);
      #1;
      n++;
    end
    if (css_nmi) report_failure("css_nmi stayed high after hsecss_fail was released");
    @(negedge rcc_rcc_hclk);
    end_test("security failure");

    start_test();
    for (i = 0; i < 8; i++) begin
      val = $urandom;
      reg_write(CR_OFS, val);
      reg_read(CR_OFS, rd);
      check_value("CR", 32'(val[N_OSC-1:0]), rd);
      check_value("osc_en", 32'(val[N_OSC-1:0]), 32'(osc_en));
      val = $urandom;
      reg_write(CIER_OFS, val);
      reg_read(CIER_OFS, rd);
      check_value("CIER", 32'(val[IRQ_W-1:0]), rd);
    end
    reg_read(CR_OFS, val);
    for (i = 6; i < 16; i++) begin
      reg_write(ADDR_W'(i), $urandom);
      reg_read(ADDR_W'(i), rd);
      check_value("unmapped read", 32'd0, rd);
    end
    reg_read(CR_OFS, rd);
    check_value("CR after unmapped writes", val, rd);
    end_test("register access");

    $display("tests: %0d run, %0d clean, %0d with errors, %0d check errors",
             tests_ok + tests_bad, tests_ok, tests_bad, total_errors());
    if (total_errors() == 0) begin
      $display("Test completed successfully");
    end else begin
      $display("Test failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

//--- hdl/bb_reset_sync.sv
`default_nettype none

module bb_reset_sync #(
  parameter int STAGE_NUM = 2  // at least 2
) (
  input  logic clk,
  input  logic src_rst_n,
  output logic gen_rst_n
);

  logic [STAGE_NUM-1:0] rst_q;

  // assert at once, release only after ones have walked through every stage
  always_ff @(posedge clk or negedge src_rst_n) begin
    if (!src_rst_n) begin
      rst_q <= '0;
    end else begin
      rst_q <= {rst_q[STAGE_NUM-2:0], 1'b1};
    end
  end

  assign gen_rst_n = rst_q[STAGE_NUM-1];

endmodule

`default_nettype wire

//--- hdl/bb_signal_sync.sv
`default_nettype none

module bb_signal_sync #(
  parameter int STAGE_NUM = 2,  // at least 2
  parameter int DW        = 1
) (
  input  logic          clk,
  input  logic          rst_n,
  input  logic [DW-1:0] src_signal,
  output logic [DW-1:0] gen_signal
);

  // stage 0 samples the asynchronous input, each later stage resolves further
  logic [STAGE_NUM-1:0][DW-1:0] sync_q;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      sync_q <= '0;
    end else begin
      sync_q <= {sync_q[STAGE_NUM-2:0], src_signal};
    end
  end

  assign gen_signal = sync_q[STAGE_NUM-1];  // last stage only

endmodule

`default_nettype wire

//--- hdl/rcc_clk_pkg.sv
`default_nettype none

package rcc_clk_pkg;

  // number of oscillator and PLL ready flags
  localparam int N_OSC = 9;

  // bit position of each source in the ready and enable vectors
  localparam int HSI_IDX   = 0;
  localparam int CSI_IDX   = 1;
  localparam int HSI48_IDX = 2;
  localparam int HSE_IDX   = 3;
  localparam int LSI_IDX   = 4;
  localparam int LSE_IDX   = 5;
  localparam int PLL1_IDX  = 6;
  localparam int PLL2_IDX  = 7;
  localparam int PLL3_IDX  = 8;

  // system clock source, as written to CFGR.SW and read from CFGR.SWS
  typedef enum logic [1:0] {
    CLK_HSI  = 2'd0,
    CLK_CSI  = 2'd1,
    CLK_HSE  = 2'd2,
    CLK_PLL1 = 2'd3
  } clk_src_e;

  localparam int SYNC_STAGES = 2;  // flops per synchronizer chain

endpackage

`default_nettype wire

//--- hdl/rcc_clk_switch.sv
`default_nettype none

module rcc_clk_switch (
  input  logic                  rcc_rcc_hclk,
  input  logic                  rst_n,
  rcc_status_if.snk             status,
  input  rcc_clk_pkg::clk_src_e sw_req,
  input  logic                  sw_wr,
  output rcc_clk_pkg::clk_src_e sws
);

  import rcc_clk_pkg::*;

  clk_src_e pend_src;
  logic     pend_vld;
  logic     css_fallback;

  // HSE and PLL1 both run from the external crystal here
  function automatic logic on_hse(input clk_src_e src);
    return (src == CLK_HSE) || (src == CLK_PLL1);
  endfunction

  // a source may be granted once its ready is seen and no HSE failure is active
  function automatic logic src_ok(input clk_src_e src, input logic [N_OSC-1:0] rdy,
                                  input logic hse_fail);
    logic r;
    case (src)
      CLK_HSI: r = rdy[HSI_IDX];
      CLK_CSI: r = rdy[CSI_IDX];
      CLK_HSE: r = rdy[HSE_IDX];
      default: r = rdy[PLL1_IDX];
    endcase
    return r && !(hse_fail && on_hse(src));
  endfunction

  assign css_fallback = status.hsecss_fail && on_hse(sws);

  always_ff @(posedge rcc_rcc_hclk or negedge rst_n) begin
    if (!rst_n) begin
      sws      <= CLK_HSI;
      pend_src <= CLK_HSI;
      pend_vld <= 1'b0;
    end else if (css_fallback) begin
      sws      <= CLK_HSI;  // drop everything and run from HSI
      pend_vld <= 1'b0;
    end else if (sw_wr) begin
      if (src_ok(sw_req, status.rdy, status.hsecss_fail)) begin
        sws      <= sw_req;
        pend_vld <= 1'b0;
      end else begin
        pend_src <= sw_req;  // replaces any older pending request
        pend_vld <= 1'b1;
      end
    end else if (pend_vld && src_ok(pend_src, status.rdy, status.hsecss_fail)) begin
      sws      <= pend_src;
      pend_vld <= 1'b0;
    end
  end

endmodule

`default_nettype wire

//--- hdl/rcc_irq_ctrl.sv
`default_nettype none

module rcc_irq_ctrl (
  input  logic                          rcc_rcc_hclk,
  input  logic                          rst_n,
  rcc_status_if.snk                     status,
  input  logic [rcc_reg_pkg::IRQ_W-1:0] irq_en,
  input  logic [rcc_reg_pkg::IRQ_W-1:0] clr,
  output logic [rcc_reg_pkg::IRQ_W-1:0] flags,
  output logic                          rcc_irq
);

  import rcc_clk_pkg::*;
  import rcc_reg_pkg::*;

  logic [N_OSC-1:0] rdy_q;  // previous ready vector
  logic [IRQ_W-1:0] set;

  always_comb begin
    set                 = '0;
    set[N_OSC-1:0]      = status.rdy & ~rdy_q;  // rising edges only
    set[CSS_BIT]        = status.hsecss_fail;
  end

  always_ff @(posedge rcc_rcc_hclk or negedge rst_n) begin
    if (!rst_n) begin
      rdy_q <= '0;
      flags <= '0;
    end else begin
      rdy_q <= status.rdy;
      flags <= (flags & ~clr) | set;  // a new event wins over a clear
    end
  end

  always_ff @(posedge rcc_rcc_hclk or negedge rst_n) begin
    if (!rst_n) begin
      rcc_irq <= 1'b0;
    end else begin
      rcc_irq <= |(flags & irq_en);
    end
  end

endmodule

`default_nettype wire

//--- hdl/rcc_reg_pkg.sv
`default_nettype none

package rcc_reg_pkg;

  localparam int ADDR_W = 4;  // word address
  localparam int DATA_W = 32;

  // *************************************************************************
  // register map
  // *************************************************************************
  localparam logic [ADDR_W-1:0] CR_OFS   = 4'h0;  // oscillator enables
  localparam logic [ADDR_W-1:0] CFGR_OFS = 4'h1;  // sw request and sws readback
  localparam logic [ADDR_W-1:0] SR_OFS   = 4'h2;  // synchronized status, read only
  localparam logic [ADDR_W-1:0] CIER_OFS = 4'h3;  // interrupt enables
  localparam logic [ADDR_W-1:0] CIFR_OFS = 4'h4;  // interrupt flags, read only
  localparam logic [ADDR_W-1:0] CICR_OFS = 4'h5;  // write one to clear

  // interrupt vector is one bit per ready flag plus the clock security bit on top
  localparam int CSS_BIT = rcc_clk_pkg::N_OSC;
  localparam int IRQ_W   = rcc_clk_pkg::N_OSC + 1;

  // extra status bits in SR above the ready flags
  localparam int SR_LSECSS_BIT = rcc_clk_pkg::N_OSC;
  localparam int SR_HSECSS_BIT = rcc_clk_pkg::N_OSC + 1;
  localparam int SR_FAULT_BIT  = rcc_clk_pkg::N_OSC + 2;

  // *************************************************************************
  // reset values
  // *************************************************************************
  localparam logic [DATA_W-1:0] CR_RST   = DATA_W'(1) << rcc_clk_pkg::HSI_IDX;
  localparam logic [DATA_W-1:0] CIER_RST = '0;

endpackage

`default_nettype wire

//--- hdl/rcc_regs.sv
`default_nettype none

module rcc_regs (
  input  logic                           rcc_rcc_hclk,
  input  logic                           rst_n,
  input  logic                           reg_sel,
  input  logic                           reg_wr,
  input  logic [rcc_reg_pkg::ADDR_W-1:0] reg_addr,
  input  logic [rcc_reg_pkg::DATA_W-1:0] reg_wdata,
  output logic [rcc_reg_pkg::DATA_W-1:0] reg_rdata,
  output logic                           reg_rvalid,
  rcc_status_if.snk                      status,
  input  rcc_clk_pkg::clk_src_e          sws,
  input  logic [rcc_reg_pkg::IRQ_W-1:0]  flags,
  output logic [rcc_clk_pkg::N_OSC-1:0]  osc_en,
  output rcc_clk_pkg::clk_src_e          sw_req,
  output logic                           sw_wr,
  output logic [rcc_reg_pkg::IRQ_W-1:0]  irq_en,
  output logic [rcc_reg_pkg::IRQ_W-1:0]  clr
);

  import rcc_clk_pkg::*;
  import rcc_reg_pkg::*;

  logic              wr_en;
  logic              rd_en;
  logic [DATA_W-1:0] rd_mux;

  assign wr_en = reg_sel && reg_wr;
  assign rd_en = reg_sel && !reg_wr;

  // *************************************************************************
  // writable registers
  // *************************************************************************
  always_ff @(posedge rcc_rcc_hclk or negedge rst_n) begin
    if (!rst_n) begin
      osc_en <= CR_RST[N_OSC-1:0];
      sw_req <= CLK_HSI;
      sw_wr  <= 1'b0;
      irq_en <= CIER_RST[IRQ_W-1:0];
      clr    <= '0;
    end else begin
      sw_wr <= wr_en && (reg_addr == CFGR_OFS);  // one pulse per CFGR write
      clr   <= '0;
      if (wr_en) begin
        case (reg_addr)
          CR_OFS:   osc_en <= reg_wdata[N_OSC-1:0];
          CFGR_OFS: sw_req <= clk_src_e'(reg_wdata[1:0]);
          CIER_OFS: irq_en <= reg_wdata[IRQ_W-1:0];
          CICR_OFS: clr    <= reg_wdata[IRQ_W-1:0];
          default:  ;  // SR, CIFR and holes are read only
        endcase
      end
    end
  end

  // *************************************************************************
  // read path
  // *************************************************************************
  always_comb begin
    rd_mux = '0;
    case (reg_addr)
      CR_OFS:   rd_mux[N_OSC-1:0] = osc_en;
      CFGR_OFS: rd_mux[3:0]       = {sws, sw_req};
      SR_OFS: begin
        rd_mux[N_OSC-1:0]     = status.rdy;
        rd_mux[SR_LSECSS_BIT] = status.lsecss_fail;
        rd_mux[SR_HSECSS_BIT] = status.hsecss_fail;
        rd_mux[SR_FAULT_BIT]  = status.hse_fault_sys;  // sys_clk fault level
      end
      CIER_OFS: rd_mux[IRQ_W-1:0] = irq_en;
      CIFR_OFS: rd_mux[IRQ_W-1:0] = flags;
      default:  rd_mux = '0;  // CICR reads back as zero too
    endcase
  end

  always_ff @(posedge rcc_rcc_hclk or negedge rst_n) begin
    if (!rst_n) begin
      reg_rvalid <= 1'b0;
    end else begin
      reg_rvalid <= rd_en;
    end
  end

  always_ff @(posedge rcc_rcc_hclk) begin
    if (rd_en) begin
      reg_rdata <= rd_mux;
    end
  end

endmodule

`default_nettype wire

//--- hdl/rcc_signal_sync.sv
`default_nettype none

module rcc_signal_sync #(
  parameter int STAGE_NUM = 2
) (
  input  logic                         sys_clk,
  input  logic                         rcc_rcc_hclk,
  input  logic                         rcc_rcc_sync_rst_n,
  input  logic [rcc_clk_pkg::N_OSC-1:0] osc_rdy,
  input  logic                         lsecss_fail,
  input  logic                         hsecss_fail,
  rcc_status_if.src                    status,
  output logic                         async_hsecss_fail  // async assert, sync release
);

  import rcc_clk_pkg::*;

  logic [1:0] css_sync;     // {lse, hse} after the chain
  logic       hse_ok;
  logic       hse_fault_n;

  // *************************************************************************
  // hclk domain, ready and fail flags
  // *************************************************************************
  bb_signal_sync #(
    .STAGE_NUM (STAGE_NUM),
    .DW        (N_OSC)
  ) u_rdy_sync (
    .clk        (rcc_rcc_hclk),
    .rst_n      (rcc_rcc_sync_rst_n),
    .src_signal (osc_rdy),
    .gen_signal (status.rdy)
  );

  bb_signal_sync #(
    .STAGE_NUM (STAGE_NUM),
    .DW        (2)
  ) u_css_sync (
    .clk        (rcc_rcc_hclk),
    .rst_n      (rcc_rcc_sync_rst_n),
    .src_signal ({lsecss_fail, hsecss_fail}),
    .gen_signal (css_sync)
  );

  assign status.lsecss_fail = css_sync[1];
  assign status.hsecss_fail = css_sync[0];

  // *************************************************************************
  // sys_clk domain, the HSE failure acts as the reset of its own chain
  // *************************************************************************
  assign hse_ok = ~hsecss_fail;

  bb_reset_sync #(
    .STAGE_NUM (STAGE_NUM)
  ) u_hse_fault_sync (
    .clk       (sys_clk),
    .src_rst_n (hse_ok),
    .gen_rst_n (hse_fault_n)
  );

  assign async_hsecss_fail    = ~hse_fault_n;
  assign status.hse_fault_sys = ~hse_fault_n;

endmodule

`default_nettype wire

//--- hdl/rcc_status_if.sv
`default_nettype none

interface rcc_status_if;

  import rcc_clk_pkg::*;

  logic [N_OSC-1:0] rdy;            // hclk synchronized ready flags
  logic             lsecss_fail;    // hclk synchronized
  logic             hsecss_fail;    // hclk synchronized
  logic             hse_fault_sys;  // sys_clk domain, asserts asynchronously

  modport src (
    output rdy,
    output lsecss_fail,
    output hsecss_fail,
    output hse_fault_sys
  );

  modport snk (
    input rdy,
    input lsecss_fail,
    input hsecss_fail,
    input hse_fault_sys
  );

endinterface

`default_nettype wire

//--- hdl/rcc_top.sv
`default_nettype none

module rcc_top #(
  parameter int STAGE_NUM = rcc_clk_pkg::SYNC_STAGES
) (
  input  logic                           rst_n,
  input  logic                           sys_clk,
  input  logic                           rcc_rcc_hclk,
  input  logic [rcc_clk_pkg::N_OSC-1:0]  osc_rdy,
  input  logic                           lsecss_fail,
  input  logic                           hsecss_fail,
  input  logic                           reg_sel,
  input  logic                           reg_wr,
  input  logic [rcc_reg_pkg::ADDR_W-1:0] reg_addr,
  input  logic [rcc_reg_pkg::DATA_W-1:0] reg_wdata,
  output logic [rcc_reg_pkg::DATA_W-1:0] reg_rdata,
  output logic                           reg_rvalid,
  output logic [rcc_clk_pkg::N_OSC-1:0]  osc_en,
  output rcc_clk_pkg::clk_src_e          sys_clk_sel,
  output logic                           rcc_irq,
  output logic                           css_nmi
);

  import rcc_clk_pkg::*;
  import rcc_reg_pkg::*;

  logic             rcc_rcc_sync_rst_n;
  clk_src_e         sw_req;
  logic             sw_wr;
  clk_src_e         sws;
  logic [IRQ_W-1:0] irq_en;
  logic [IRQ_W-1:0] clr;
  logic [IRQ_W-1:0] flags;

  rcc_status_if u_status ();

  // hclk reset, released in step with the clock
  bb_reset_sync #(
    .STAGE_NUM (STAGE_NUM)
  ) u_hclk_rst_sync (
    .clk       (rcc_rcc_hclk),
    .src_rst_n (rst_n),
    .gen_rst_n (rcc_rcc_sync_rst_n)
  );

  rcc_signal_sync #(
    .STAGE_NUM (STAGE_NUM)
  ) u_rcc_signal_sync (
    .sys_clk            (sys_clk),
    .rcc_rcc_hclk       (rcc_rcc_hclk),
    .rcc_rcc_sync_rst_n (rcc_rcc_sync_rst_n),
    .osc_rdy            (osc_rdy),
    .lsecss_fail        (lsecss_fail),
    .hsecss_fail        (hsecss_fail),
    .status             (u_status.src),
    .async_hsecss_fail  (css_nmi)
  );

  rcc_clk_switch u_rcc_clk_switch (
    .rcc_rcc_hclk (rcc_rcc_hclk),
    .rst_n        (rcc_rcc_sync_rst_n),
    .status       (u_status.snk),
    .sw_req       (sw_req),
    .sw_wr        (sw_wr),
    .sws          (sws)
  );

  rcc_irq_ctrl u_rcc_irq_ctrl (
    .rcc_rcc_hclk (rcc_rcc_hclk),
    .rst_n        (rcc_rcc_sync_rst_n),
    .status       (u_status.snk),
    .irq_en       (irq_en),
    .clr          (clr),
    .flags        (flags),
    .rcc_irq      (rcc_irq)
  );

  rcc_regs u_rcc_regs (
    .rcc_rcc_hclk (rcc_rcc_hclk),
    .rst_n        (rcc_rcc_sync_rst_n),
    .reg_sel      (reg_sel),
    .reg_wr       (reg_wr),
    .reg_addr     (reg_addr),
    .reg_wdata    (reg_wdata),
    .reg_rdata    (reg_rdata),
    .reg_rvalid   (reg_rvalid),
    .status       (u_status.snk),
    .sws          (sws),
    .flags        (flags),
    .osc_en       (osc_en),
    .sw_req       (sw_req),
    .sw_wr        (sw_wr),
    .irq_en       (irq_en),
    .clr          (clr)
  );

  assign sys_clk_sel = sws;

endmodule

`default_nettype wire

//--- run.sh
#!/usr/bin/env bash
set -u

cd "$(dirname "$0")" || exit 1

top=tb_rcc_top
log=sim.log

verilator --binary --timing --assert -f vlog.f --top-module "$top" -o "$top"
if [ $? -ne 0 ]; then
  echo "verilator build step returned an error"
  exit 1
fi

./obj_dir/"$top" > "$log" 2>&1
run_status=$?
cat "$log"
if [ $run_status -ne 0 ]; then
  echo "simulation exited with status $run_status"
  exit 1
fi

if grep -q "Test failed" "$log"; then
  exit 1
fi
exit 0

//--- vlog.f
hdl/rcc_clk_pkg.sv
hdl/rcc_reg_pkg.sv
hdl/rcc_status_if.sv
hdl/bb_signal_sync.sv
hdl/bb_reset_sync.sv
hdl/rcc_signal_sync.sv
hdl/rcc_clk_switch.sv
hdl/rcc_irq_ctrl.sv
hdl/rcc_regs.sv
hdl/rcc_top.sv
bench/tb_rcc_top.sv
